//--- common/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// core data path width
`define DATA_W 32

// real byte-address bits (64 KiB)
// upper core address bits are dropped so accesses wrap
`define MEM_ADDR_W 16

// register byte offsets on the AXI4-Lite port
`define REG_CTRL       32'h0000_0000
`define REG_FAULT_CNT  32'h0000_0004
`define REG_FAULT_ADDR 32'h0000_0008

`endif

//--- common/memPkg.sv
package memPkg;

    // core-side memory operation, codes match the core's funct encoding
    typedef enum logic [2:0] {
        LB  = 3'd0,  // load byte, sign extended
        LH  = 3'd1,  // load halfword, sign extended
        LW  = 3'd2,
        LBU = 3'd3,  // load byte, zero extended
        LHU = 3'd4,  // load halfword, zero extended
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } memOpT;

    // AXI4-Lite response codes
    // EXOKAY and DECERR are never returned by this slave
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axiRespT;

    // register selected by an AXI address
    typedef enum logic [1:0] {
        SEL_CTRL,        // bit 0 enables the alignment check
        SEL_FAULT_CNT,   // saturating count of suppressed accesses
        SEL_FAULT_ADDR,  // address of the most recent suppressed access
        SEL_NONE         // unmapped offset
    } regSelT;

endpackage

//--- dataMem/byteArray.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module byteArray (
    input  logic                   clk,
    input  logic [`MEM_ADDR_W-1:0] laneAddr,
    input  logic [3:0]             byteEn,
    input  logic [31:0]            wrLanes,
    output logic [31:0]            rdLanes
);

    localparam int Depth = 1 << `MEM_ADDR_W;

    logic [7:0]             mem [Depth];
    logic [`MEM_ADDR_W-1:0] laneIdx [4];

    // memory starts out all zero
    initial begin
        for (int i = 0; i < Depth; i++) begin
            mem[i] = 8'h00;
        end
    end

    // lane k covers byte laneAddr+k
    // the adder width makes the top of memory wrap to 0
    for (genvar k = 0; k < 4; k++) begin : gLane
        localparam logic [`MEM_ADDR_W-1:0] LaneOff = k;

        assign laneIdx[k] = laneAddr + LaneOff;
        assign rdLanes[8*k +: 8] = mem[laneIdx[k]];  // async read
    end

    // byte writes on the rising edge, one enable per lane
    always_ff @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            if (byteEn[k]) begin
                mem[laneIdx[k]] <= wrLanes[8*k +: 8];
            end
        end
    end

endmodule

//--- dataMem/loadStoreUnit.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module loadStoreUnit (
    input  memPkg::memOpT          memOp,
    input  logic [31:0]            addr,
    input  logic [`DATA_W-1:0]     writeData,
    input  logic                   checkAlign,
    output logic [`DATA_W-1:0]     readData,
    output logic                   misaligned,
    output logic                   faultPulse,
    output logic [31:0]            faultAddr,
    output logic [`MEM_ADDR_W-1:0] laneAddr,
    output logic [3:0]             byteEn,
    output logic [31:0]            wrLanes,
    input  logic [31:0]            rdLanes
);
    import memPkg::*;

    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_HALF,
        SZ_WORD
    } accSizeT;

    accSizeT     accSize;
    logic        isStore;
    logic        isSigned;
    logic        suppress;
    logic [3:0]  sizeMask;
    logic [31:0] loadVal;

    // operation decode
    always_comb begin
        accSize  = SZ_WORD;
        isSigned = 1'b0;
        isStore  = 1'b0;
        case (memOp)
            LB: begin
                accSize  = SZ_BYTE;
                isSigned = 1'b1;
            end
            LH: begin
                accSize  = SZ_HALF;
                isSigned = 1'b1;
            end
            LW:  accSize = SZ_WORD;
            LBU: accSize = SZ_BYTE;
            LHU: accSize = SZ_HALF;
            SB: begin
                accSize = SZ_BYTE;
                isStore = 1'b1;
            end
            SH: begin
                accSize = SZ_HALF;
                isStore = 1'b1;
            end
            SW: begin
                accSize = SZ_WORD;
                isStore = 1'b1;
            end
            default: accSize = SZ_WORD;
        endcase
    end

    // natural alignment per access size
    always_comb begin
        case (accSize)
            SZ_HALF: misaligned = addr[0];
            SZ_WORD: misaligned = |addr[1:0];
            default: misaligned = 1'b0;  // bytes are always aligned
        endcase
    end

    assign suppress   = misaligned && checkAlign;
    assign faultPulse = suppress;
    assign faultAddr  = addr;

    always_comb begin
        case (accSize)
            SZ_BYTE: sizeMask = 4'b0001;
            SZ_HALF: sizeMask = 4'b0011;
            default: sizeMask = 4'b1111;
        endcase
    end

    assign laneAddr = addr[`MEM_ADDR_W-1:0];  // upper bits dropped
    assign wrLanes  = writeData;              // lane 0 holds the low byte
    assign byteEn   = (isStore && !suppress) ? sizeMask : 4'b0000;

    // little-endian load with sign or zero extension
    always_comb begin
        if (isStore) begin
            loadVal = rdLanes;  // stores show the addressed word
        end else begin
            case (accSize)
                SZ_BYTE: loadVal = {{24{isSigned & rdLanes[7]}}, rdLanes[7:0]};
                SZ_HALF: loadVal = {{16{isSigned & rdLanes[15]}}, rdLanes[15:0]};
                default: loadVal = rdLanes;
            endcase
        end
        readData = suppress ? '0 : loadVal;
    end

    // loads never write and faults need a misaligned halfword or word op
    always_comb begin
        assert final ((memOp inside {SB, SH, SW}) || byteEn == 4'b0000)
            else $error("byte enables active on load op %s", memOp.name());
        assert final (!faultPulse || (checkAlign &&
                      ((memOp inside {LH, LHU, SH} && addr[0]) ||
                       (memOp inside {LW, SW} && addr[1:0] != 2'b00))))
            else $error("fault raised for aligned address %h", addr);
    end

endmodule

//--- hw/memCtrlRegs.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module memCtrlRegs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [31:0]          awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [`DATA_W-1:0]   wdata,
    input  logic [`DATA_W/8-1:0] wstrb,
    input  logic                 wvalid,
    output logic                 wready,
    output memPkg::axiRespT      bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  logic [31:0]          araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output logic [`DATA_W-1:0]   rdata,
    output memPkg::axiRespT      rresp,
    output logic                 rvalid,
    input  logic                 rready,
    input  logic                 faultPulse,
    input  logic [31:0]          faultAddr,
    output logic                 checkAlign
);
    import memPkg::*;

    typedef enum logic [1:0] {
        W_IDLE,
        W_ACK,   // awready and wready high
        W_RESP   // bvalid high until bready
    } wrStateT;

    typedef enum logic [1:0] {
        R_IDLE,
        R_ACK,   // arready high
        R_DATA   // rvalid high until rready
    } rdStateT;

    wrStateT     wrState;
    rdStateT     rdState;
    regSelT      wrSel;
    regSelT      rdSel;
    logic        wrFire;
    logic        cntClear;
    logic [31:0] faultCnt;
    logic [31:0] faultAddrReg;

    function automatic regSelT decodeReg(input logic [31:0] a);
        case (a)
            `REG_CTRL:       return SEL_CTRL;
            `REG_FAULT_CNT:  return SEL_FAULT_CNT;
            `REG_FAULT_ADDR: return SEL_FAULT_ADDR;
            default:         return SEL_NONE;
        endcase
    endfunction

    // write channel
    always_ff @(posedge clk) begin
        if (reset) begin
            wrState <= W_IDLE;
        end else begin
            case (wrState)
                W_IDLE: begin
                    if (awvalid && wvalid) begin
                        wrState <= W_ACK;
                    end
                end
                W_ACK:  wrState <= W_RESP;
                W_RESP: begin
                    if (bready) begin
                        wrState <= W_IDLE;
                    end
                end
                default: wrState <= W_IDLE;
            endcase
        end
    end

    assign wrFire   = (wrState == W_ACK);  // address and data taken here
    assign awready  = wrFire;
    assign wready   = wrFire;
    assign bvalid   = (wrState == W_RESP);
    assign wrSel    = decodeReg(awaddr);
    assign cntClear = wrFire && (wrSel == SEL_FAULT_CNT);

    always_ff @(posedge clk) begin
        if (wrFire) begin
            if (wrSel == SEL_CTRL || wrSel == SEL_FAULT_CNT) begin
                bresp <= OKAY;
            end else begin
                bresp <= SLVERR;  // read-only or unmapped
            end
        end
    end

    // CTRL lives in byte 0
    always_ff @(posedge clk) begin
        if (reset) begin
            checkAlign <= 1'b0;
        end else if (wrFire && wrSel == SEL_CTRL && wstrb[0]) begin
            checkAlign <= wdata[0];
        end
    end

    // fault tracking, a clear from the bus beats a fault on the same edge
    always_ff @(posedge clk) begin
        if (reset) begin
            faultCnt     <= '0;
            faultAddrReg <= '0;
        end else begin
            if (cntClear) begin
                faultCnt <= '0;
            end else if (faultPulse && faultCnt != '1) begin
                faultCnt <= faultCnt + 32'd1;  // saturates at all ones
            end
            if (faultPulse) begin
                faultAddrReg <= faultAddr;
            end
        end
    end

    // read channel
    always_ff @(posedge clk) begin
        if (reset) begin
            rdState <= R_IDLE;
        end else begin
            case (rdState)
                R_IDLE: begin
                    if (arvalid) begin
                        rdState <= R_ACK;
                    end
                end
                R_ACK:  rdState <= R_DATA;
                R_DATA: begin
                    if (rready) begin
                        rdState <= R_IDLE;
                    end
                end
                default: rdState <= R_IDLE;
            endcase
        end
    end

    assign arready = (rdState == R_ACK);
    assign rvalid  = (rdState == R_DATA);
    assign rdSel   = decodeReg(araddr);

    always_ff @(posedge clk) begin
        if (arready) begin
            rresp <= OKAY;
            case (rdSel)
                SEL_CTRL:       rdata <= {{(`DATA_W-1){1'b0}}, checkAlign};
                SEL_FAULT_CNT:  rdata <= faultCnt;
                SEL_FAULT_ADDR: rdata <= faultAddrReg;
                default: begin
                    rdata <= '0;
                    rresp <= SLVERR;
                end
            endcase
        end
    end

    // write response must stay up until the master takes it
    bvalidHold: assert property (
        @(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid
    ) else $error("bvalid dropped before bready");

endmodule

//--- hw/dataMemTop.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module dataMemTop (
    input  logic                 clk,
    input  logic                 reset,
    // core port
    input  memPkg::memOpT        memOp,
    input  logic [31:0]          addr,
    input  logic [`DATA_W-1:0]   writeData,
    output logic [`DATA_W-1:0]   readData,
    output logic                 misaligned,
    // AXI4-Lite register port
    input  logic [31:0]          awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [`DATA_W-1:0]   wdata,
    input  logic [`DATA_W/8-1:0] wstrb,
    input  logic                 wvalid,
    output logic                 wready,
    output memPkg::axiRespT      bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  logic [31:0]          araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output logic [`DATA_W-1:0]   rdata,
    output memPkg::axiRespT      rresp,
    output logic                 rvalid,
    input  logic                 rready
);

    logic                   checkAlign;
    logic                   faultPulse;
    logic [31:0]            faultAddr;
    logic [`MEM_ADDR_W-1:0] laneAddr;
    logic [3:0]             byteEn;
    logic [31:0]            wrLanes;
    logic [31:0]            rdLanes;

    memCtrlRegs memCtrlRegs_inst (
        .clk        (clk),
        .reset      (reset),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .faultPulse (faultPulse),
        .faultAddr  (faultAddr),
        .checkAlign (checkAlign)
    );

    loadStoreUnit loadStoreUnit_inst (
        .memOp      (memOp),
        .addr       (addr),
        .writeData  (writeData),
        .checkAlign (checkAlign),
        .readData   (readData),
        .misaligned (misaligned),
        .faultPulse (faultPulse),
        .faultAddr  (faultAddr),
        .laneAddr   (laneAddr),
        .byteEn     (byteEn),
        .wrLanes    (wrLanes),
        .rdLanes    (rdLanes)
    );

    byteArray byteArray_inst (
        .clk      (clk),
        .laneAddr (laneAddr),
        .byteEn   (byteEn),
        .wrLanes  (wrLanes),
        .rdLanes  (rdLanes)
    );

endmodule

//--- sim/dataMemTb.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module dataMemTb;
    import memPkg::*;

    localparam int TotalOps = 3000;  // core and AXI operations over all tests
    localparam int FaultOps = 24;
    localparam int MemBytes = 1 << `MEM_ADDR_W;

    logic         clk;
    logic         reset;
    memOpT        memOp;
    logic [31:0]  addr;
    logic [31:0]  writeData;
    logic [31:0]  readData;
    logic         misaligned;
    logic [31:0]  awaddr;
    logic         awvalid;
    logic         awready;
    logic [31:0]  wdata;
    logic [3:0]   wstrb;
    logic         wvalid;
    logic         wready;
    axiRespT      bresp;
    logic         bvalid;
    logic         bready;
    logic [31:0]  araddr;
    logic         arvalid;
    logic         arready;
    logic [31:0]  rdata;
    axiRespT      rresp;
    logic         rvalid;
    logic         rready;

    logic [7:0]   model [MemBytes];  // reference byte array
    logic         expCheck;
    logic [31:0]  expFaultAddr;
    string        curTest;
    int           testChecks;
    int           testErrors;
    int           totalChecks;
    int           totalErrors;
    int           testCount;
    integer       seed;
    memOpT        misOps [5] = '{SH, SW, LH, LHU, LW};

    dataMemTop dataMemTop_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int randBelow(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic isMisaligned(input memOpT op, input logic [31:0] a);
        case (op)
            LH, LHU, SH: return a[0];
            LW, SW:      return a[1:0] != 2'b00;
            default:     return 1'b0;
        endcase
    endfunction

    // byte k of an access wraps at the top of memory
    function automatic logic [`MEM_ADDR_W-1:0] byteIndex(input logic [31:0] a, input int k);
        logic [`MEM_ADDR_W-1:0] off;
        off = k;
        return a[`MEM_ADDR_W-1:0] + off;
    endfunction

    // expected little-endian readData for a load
    function automatic logic [31:0] expectedLoad(input memOpT op, input logic [31:0] a,
                                                 input logic chk);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        b0 = model[byteIndex(a, 0)];
        b1 = model[byteIndex(a, 1)];
        b2 = model[byteIndex(a, 2)];
        b3 = model[byteIndex(a, 3)];
        if (chk && isMisaligned(op, a)) begin
            return 32'h0;  // suppressed
        end
        case (op)
            LB:      return {{24{b0[7]}}, b0};
            LBU:     return {24'h0, b0};
            LH:      return {{16{b1[7]}}, b1, b0};
            LHU:     return {16'h0, b1, b0};
            default: return {b3, b2, b1, b0};
        endcase
    endfunction

    function automatic logic [31:0] misalign(input memOpT op, input logic [31:0] a);
        if (op inside {SH, LH, LHU}) begin
            return a | 32'h1;
        end
        return (a & ~32'h3) | (randBelow(3) + 1);
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
        testErrors++;
        $display("CHECK FAILED %s %s: expected %h actual %h", curTest, what, exp, act);
    endtask

    task automatic idleCore();
        memOp     = LW;  // aligned load at 0, never faults
        addr      = 32'h0;
        writeData = 32'h0;
    endtask

    task automatic coreOp(input memOpT op, input logic [31:0] a, input logic [31:0] d);
        @(negedge clk);
        memOp     = op;
        addr      = a;
        writeData = d;
    endtask

    task automatic axiWrite(input logic [31:0] a, input logic [31:0] d, output axiRespT resp);
        @(negedge clk);
        idleCore();
        awaddr  = a;
        wdata   = d;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(negedge clk); while (!awready);
        @(negedge clk);  // handshake edge has passed
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(negedge clk);  // bready still low over this edge
        testChecks++;
        if (!bvalid) begin
            testErrors++;
            $display("bvalid dropped before bready in test %s", curTest);
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        if (a == `REG_CTRL) begin
            expCheck = d[0];
        end
    endtask

    task automatic axiRead(input logic [31:0] a, output logic [31:0] d, output axiRespT resp);
        @(negedge clk);
        idleCore();
        araddr  = a;
        arvalid = 1'b1;
        do @(negedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        d    = rdata;
        resp = rresp;
    endtask

    task automatic checkWrite(input logic [31:0] a, input logic [31:0] d, input axiRespT expResp);
        axiRespT r;
        axiWrite(a, d, r);
        testChecks++;
        if (r !== expResp) reportMismatch("bresp", expResp, r);
    endtask

    task automatic checkRead(input logic [31:0] a, input logic [31:0] expData,
                             input axiRespT expResp);
        logic [31:0] d;
        axiRespT     r;
        axiRead(a, d, r);
        testChecks += 2;
        if (d !== expData) reportMismatch("rdata", expData, d);
        if (r !== expResp) reportMismatch("rresp", expResp, r);
    endtask

    task automatic finishTest();
        @(negedge clk);  // last access already checked
        idleCore();
        $display("test %-20s %0d checks, %0d errors", curTest, testChecks, testErrors);
        totalChecks += testChecks;
        totalErrors += testErrors;
        testCount++;
        testChecks = 0;
        testErrors = 0;
    endtask

    // scoreboard samples just before each rising edge
    initial begin : scoreboard
        logic expMis;
        logic [31:0] expData;
        forever begin
            @(negedge clk);
            #4;
            if (!reset) begin
                expMis  = isMisaligned(memOp, addr);
                expData = expectedLoad(memOp, addr, expCheck);
                testChecks++;
                if (misaligned !== expMis) reportMismatch("misaligned", expMis, misaligned);
                if (!(memOp inside {SB, SH, SW})) begin
                    testChecks++;
                    if (readData !== expData) reportMismatch("readData", expData, readData);
                end
                if (expCheck && expMis) begin
                    expFaultAddr = addr;  // store blocked too
                end else if (memOp inside {SB, SH, SW}) begin
                    for (int k = 0; k < (memOp == SB ? 1 : memOp == SH ? 2 : 4); k++) begin
                        model[byteIndex(addr, k)] = writeData[8*k +: 8];
                    end
                end
            end
        end
    end

    initial begin : watchdog
        repeat (TotalOps * 20 + 1000) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", TotalOps * 20 + 1000);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] base;
        logic [31:0] a;
        memOpT       op;
        seed = 32'hb139;
        reset = 1'b1;
        idleCore();
        {awaddr, awvalid, wdata, wstrb, wvalid, araddr, arvalid} = '0;
        bready = 1'b0;
        rready = 1'b1;
        expCheck = 1'b0;
        expFaultAddr = 32'h0;
        {testChecks, testErrors, totalChecks, totalErrors, testCount} = '0;
        for (int i = 0; i < MemBytes; i++) model[i] = 8'h00;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        curTest = "resetValues";
        checkRead(`REG_CTRL, 32'h0, OKAY);
        checkRead(`REG_FAULT_CNT, 32'h0, OKAY);
        checkRead(`REG_FAULT_ADDR, 32'h0, OKAY);
        finishTest();

        curTest = "randomAligned";
        repeat (400) begin
            base = $random(seed) & 32'h0000_03fc;
            case (randBelow(3))
                0:       coreOp(SB, base + randBelow(4), $random(seed));
                1:       coreOp(SH, base + 2 * randBelow(2), $random(seed));
                default: coreOp(SW, base, $random(seed));
            endcase
            coreOp(LB, base + randBelow(4), 32'h0);
            coreOp(LBU, base + randBelow(4), 32'h0);
            coreOp(LH, base + 2 * randBelow(2), 32'h0);
            coreOp(LHU, base + 2 * randBelow(2), 32'h0);
            coreOp(LW, base, 32'h0);
        end
        finishTest();

        curTest = "misalignedUnchecked";
        repeat (60) begin
            op = misOps[randBelow(5)];
            a  = misalign(op, 32'h400 + randBelow(250));
            coreOp(op, a, $random(seed));
            coreOp(LW, a & ~32'h3, 32'h0);
            coreOp(LW, (a & ~32'h3) + 4, 32'h0);
        end
        checkRead(`REG_FAULT_CNT, 32'h0, OKAY);
        finishTest();

        curTest = "checkedFaults";
        checkWrite(`REG_CTRL, 32'h1, OKAY);
        for (int i = 0; i < 16; i++) coreOp(SW, 32'h500 + 4 * i, $random(seed));
        repeat (FaultOps) begin
            op = misOps[randBelow(5)];
            coreOp(op, misalign(op, 32'h500 + randBelow(60)), $random(seed));
        end
        for (int i = 0; i < 16; i++) coreOp(LW, 32'h500 + 4 * i, 32'h0);
        checkRead(`REG_FAULT_CNT, FaultOps, OKAY);
        checkRead(`REG_FAULT_ADDR, expFaultAddr, OKAY);
        finishTest();

        curTest = "registerAccess";
        checkWrite(`REG_FAULT_CNT, 32'hdead_beef, OKAY);  // any data clears
        checkRead(`REG_FAULT_CNT, 32'h0, OKAY);
        checkRead(`REG_CTRL, 32'h1, OKAY);
        checkRead(32'h0000_000c, 32'h0, SLVERR);
        checkWrite(`REG_FAULT_ADDR, 32'h1234_5678, SLVERR);
        checkRead(`REG_FAULT_ADDR, expFaultAddr, OKAY);
        finishTest();

        curTest = "addressWrap";
        checkWrite(`REG_CTRL, 32'h0, OKAY);
        coreOp(SW, 32'h0000_fffc, 32'h8899_aabb);
        coreOp(LW, 32'h7e00_fffc, 32'h0);
        coreOp(SW, 32'habcd_fffe, 32'h1122_3344);  // spans top and bottom
        coreOp(LW, 32'h0000_0000, 32'h0);
        coreOp(LH, 32'hffff_ffff, 32'h0);
        repeat (40) begin
            a = $random(seed);
            a[15:0] = 16'hfff8 | randBelow(8);
            coreOp(memOpT'(randBelow(8)), a, $random(seed));
        end
        coreOp(LW, 32'h0000_fffc, 32'h0);
        coreOp(LW, 32'h0000_0000, 32'h0);
        finishTest();

        @(negedge clk);
        totalChecks += testChecks;
        totalErrors += testErrors;
        $display("%0d tests, %0d checks, %0d errors", testCount, totalChecks, totalErrors);
        if (totalErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+common
common/memPkg.sv
dataMem/byteArray.sv
dataMem/loadStoreUnit.sv
hw/memCtrlRegs.sv
hw/dataMemTop.sv
sim/dataMemTb.sv

//--- Bender.yml
package:
  name: data_mem

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/memPkg.sv
      - dataMem/byteArray.sv
      - dataMem/loadStoreUnit.sv
      - hw/memCtrlRegs.sv
      - hw/dataMemTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/dataMemTb.sv
